/* logic/decoder_config.svh */
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// instruction word and immediate width
`define WORD_WIDTH 32

// register file index width
`define REG_IDX_WIDTH 5

`define LINK_REG 31 // $ra

// branch-likely forms decoded unless overridden
`define IMPLEMENT_LIKELY_DEFAULT 1

`endif

/* logic/isaPkg.sv */
`include "decoder_config.svh"

package isaPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'h00, opRegimm = 6'h01, opJ     = 6'h02, opJal   = 6'h03,
        opBeq     = 6'h04, opBne    = 6'h05, opBlez  = 6'h06, opBgtz  = 6'h07,
        opAddi    = 6'h08, opAddiu  = 6'h09, opSlti  = 6'h0a, opSltiu = 6'h0b,
        opAndi    = 6'h0c, opOri    = 6'h0d, opXori  = 6'h0e, opLui   = 6'h0f,
        opBeql    = 6'h14, opBnel   = 6'h15, opBlezl = 6'h16, opBgtzl = 6'h17,
        opLb      = 6'h20, opLh     = 6'h21, opLw    = 6'h23, opLbu   = 6'h24,
        opLhu     = 6'h25, opSb     = 6'h28, opSh    = 6'h29, opSw    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll   = 6'h00, fnSrl   = 6'h02, fnSra  = 6'h03, fnSllv  = 6'h04,
        fnSrlv  = 6'h06, fnSrav  = 6'h07, fnJr   = 6'h08, fnJalr  = 6'h09,
        fnSyscall = 6'h0c, fnBreak = 6'h0d, fnMfhi = 6'h10, fnMthi = 6'h11,
        fnMflo  = 6'h12, fnMtlo  = 6'h13, fnMult = 6'h18, fnMultu = 6'h19,
        fnDiv   = 6'h1a, fnDivu  = 6'h1b, fnAdd  = 6'h20, fnAddu  = 6'h21,
        fnSub   = 6'h22, fnSubu  = 6'h23, fnAnd  = 6'h24, fnOr    = 6'h25,
        fnXor   = 6'h26, fnNor   = 6'h27, fnSlt  = 6'h2a, fnSltu  = 6'h2b
    } funct_t;

    // bit 4 links, bit 1 likely, bit 0 selects >= 0
    typedef enum logic [4:0] {
        rtBltz   = 5'h00, rtBgez   = 5'h01, rtBltzl   = 5'h02, rtBgezl   = 5'h03,
        rtBltzal = 5'h10, rtBgezal = 5'h11, rtBltzall = 5'h12, rtBgezall = 5'h13
    } regimm_t;

    typedef struct packed {
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [`REG_IDX_WIDTH-1:0] rd;
        logic [4:0]                shamt;
        funct_t                    funct;
    } rBody_t;

    typedef struct packed {
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [15:0]               imm16;
    } iBody_t;

    // R, I and J layouts overlay the low 26 bits
    typedef union packed {
        rBody_t      r;
        iBody_t      i;
        logic [25:0] target26;
    } instrBody_t;

    typedef struct packed {
        opcode_t    opcode;
        instrBody_t body;
    } instrFields_t;

endpackage

/* logic/ctrlPkg.sv */
`include "decoder_config.svh"

package ctrlPkg;

    // value 0 of every enum is the inactive choice
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor, aluSlt, aluSltu,
        aluShiftLeft, aluShiftRight, aluArithShiftRight
    } aluCtrl_t;

    typedef enum logic [2:0] {
        cmpEqual, cmpNotEqual, cmpBelowZero, cmpAtOrAboveZero,
        cmpAtOrBelowZero, cmpAboveZero
    } cmpCtrl_t;

    typedef enum logic [1:0] {memByte, memHalf, memWord} memWidth_t;

    typedef enum logic [2:0] {
        mulDisabled, mulMult, mulMultu, mulDiv, mulDivu, mulSetHi, mulSetLo
    } mulCtrl_t;

    typedef enum logic [1:0] {grfAlu, grfMem, grfPc, grfMul} grfSrc_t;

    typedef enum logic {jumpImmediate, jumpRegister} jumpLoc_t;

    typedef enum logic [1:0] {excNone, excUnknown, excSyscall, excBreak} excCode_t;

    typedef struct packed {
        logic [`REG_IDX_WIDTH-1:0] regRead1;
        logic [`REG_IDX_WIDTH-1:0] regRead2;
        logic [`REG_IDX_WIDTH-1:0] destinationRegister; // 0 means no write
        aluCtrl_t                  aluCtrl;
        logic                      aluSrc; // B operand from immediate
        logic [`WORD_WIDTH-1:0]    immediate;
        logic                      checkOverflow;
        logic                      branch;
        logic                      branchLikely;
        cmpCtrl_t                  cmpCtrl;
        logic                      absJump;
        jumpLoc_t                  absJumpLoc;
        logic                      memLoad;
        logic                      memStore;
        memWidth_t                 memWidthCtrl;
        logic                      memReadSignExtend;
        logic                      calculateAddress;
        mulCtrl_t                  mulCtrl;
        logic                      mulEnable;
        logic                      mulOutputSel; // 1 selects HI
        grfSrc_t                   grfWriteSource;
        excCode_t                  generateException;
    } controlWord_t;

    localparam controlWord_t kControlNop = '0;

endpackage

/* logic/specialDecoder.sv */
`timescale 1ns/1ps
`include "decoder_config.svh"

module specialDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instrFields_t fields,
    output controlWord_t word,
    output logic         claim
);

    logic [`REG_IDX_WIDTH-1:0] rs;
    logic [`REG_IDX_WIDTH-1:0] rt;
    logic [`REG_IDX_WIDTH-1:0] rd;
    funct_t                    funct;

    assign rs = fields.body.r.rs;
    assign rt = fields.body.r.rt;
    assign rd = fields.body.r.rd;
    assign funct = fields.body.r.funct;

    always_comb
    begin
        word = kControlNop;
        claim = 1'b0;
        if (fields.opcode == opSpecial)
        begin
            claim = 1'b1;
            case (funct)
                fnAddu, fnSubu, fnAdd, fnSub, fnAnd, fnOr, fnNor, fnXor, fnSlt, fnSltu:
                begin
                    word.regRead1 = rs;
                    word.regRead2 = rt;
                    word.destinationRegister = rd;
                    word.checkOverflow = funct inside {fnAdd, fnSub};
                end
                fnSll, fnSrl, fnSra:
                begin
                    word.regRead1 = rt;
                    word.destinationRegister = rd;
                    word.aluSrc = 1'b1;
                    word.immediate = `WORD_WIDTH'(fields.body.r.shamt);
                end
                fnSllv, fnSrlv, fnSrav:
                begin
                    word.regRead1 = rt; // value to shift
                    word.regRead2 = rs; // amount
                    word.destinationRegister = rd;
                end
                fnJr, fnJalr:
                begin
                    word.regRead1 = rs;
                    word.absJump = 1'b1;
                    word.absJumpLoc = jumpRegister;
                    if (funct == fnJalr)
                    begin
                        word.grfWriteSource = grfPc;
                        word.destinationRegister = rd;
                    end
                end
                fnMult, fnMultu, fnDiv, fnDivu:
                begin
                    word.regRead1 = rs;
                    word.regRead2 = rt;
                end
                fnMthi, fnMtlo:
                    word.regRead1 = rs;
                fnMfhi, fnMflo:
                begin
                    word.mulOutputSel = funct == fnMfhi;
                    word.destinationRegister = rd;
                    word.grfWriteSource = grfMul;
                end
                fnSyscall:
                    word.generateException = excSyscall;
                fnBreak:
                    word.generateException = excBreak;
                default:
                    claim = 1'b0;
            endcase

            case (funct)
                fnSubu, fnSub:  word.aluCtrl = aluSub;
                fnAnd:          word.aluCtrl = aluAnd;
                fnOr:           word.aluCtrl = aluOr;
                fnNor:          word.aluCtrl = aluNor;
                fnXor:          word.aluCtrl = aluXor;
                fnSlt:          word.aluCtrl = aluSlt;
                fnSltu:         word.aluCtrl = aluSltu;
                fnSll, fnSllv:  word.aluCtrl = aluShiftLeft;
                fnSrl, fnSrlv:  word.aluCtrl = aluShiftRight;
                fnSra, fnSrav:  word.aluCtrl = aluArithShiftRight;
                fnMult:         word.mulCtrl = mulMult;
                fnMultu:        word.mulCtrl = mulMultu;
                fnDiv:          word.mulCtrl = mulDiv;
                fnDivu:         word.mulCtrl = mulDivu;
                fnMthi:         word.mulCtrl = mulSetHi;
                fnMtlo:         word.mulCtrl = mulSetLo;
                default:        ; // add, or no ALU use
            endcase
        end
    end

endmodule

/* logic/branchDecoder.sv */
`timescale 1ns/1ps
`include "decoder_config.svh"

module branchDecoder
    import isaPkg::*;
    import ctrlPkg::*;
#(
    parameter bit implementLikely = `IMPLEMENT_LIKELY_DEFAULT
) (
    input  instrFields_t fields,
    output controlWord_t word,
    output logic         claim
);

    logic [`REG_IDX_WIDTH-1:0] rt;
    logic [`WORD_WIDTH-1:0]    offset;
    logic                      likely;

    assign rt = fields.body.i.rt;
    assign offset = {{(`WORD_WIDTH-16){fields.body.i.imm16[15]}}, fields.body.i.imm16};

    always_comb
    begin
        word = kControlNop;
        claim = 1'b0;
        likely = 1'b0;
        case (fields.opcode)
            opRegimm, opBeq, opBne, opBlez, opBgtz, opBeql, opBnel, opBlezl, opBgtzl:
            begin
                word.regRead1 = fields.body.i.rs;
                word.branch = 1'b1;
                word.immediate = offset;
                if (fields.opcode == opRegimm)
                begin
                    likely = rt[1];
                    claim = regimm_t'(rt) inside {rtBltz, rtBgez, rtBltzl, rtBgezl,
                        rtBltzal, rtBgezal, rtBltzall, rtBgezall};
                    word.cmpCtrl = rt[0] ? cmpAtOrAboveZero : cmpBelowZero;
                    if (rt[4])
                    begin
                        word.grfWriteSource = grfPc;
                        word.destinationRegister = `REG_IDX_WIDTH'(`LINK_REG);
                    end
                end
                else
                begin
                    likely = fields.opcode inside {opBeql, opBnel, opBlezl, opBgtzl};
                    claim = 1'b1;
                    case (fields.opcode)
                        opBeq, opBeql:   word.cmpCtrl = cmpEqual;
                        opBne, opBnel:   word.cmpCtrl = cmpNotEqual;
                        opBlez, opBlezl: word.cmpCtrl = cmpAtOrBelowZero;
                        default:         word.cmpCtrl = cmpAboveZero;
                    endcase
                    if (fields.opcode inside {opBeq, opBne, opBeql, opBnel})
                        word.regRead2 = rt;
                end
                word.branchLikely = likely;
                if (likely && !implementLikely)
                    claim = 1'b0; // left to the unknown exception
            end
            opJ, opJal:
            begin
                claim = 1'b1;
                word.absJump = 1'b1;
                word.absJumpLoc = jumpImmediate;
                word.immediate = `WORD_WIDTH'(fields.body.target26);
                if (fields.opcode == opJal)
                begin
                    word.grfWriteSource = grfPc;
                    word.destinationRegister = `REG_IDX_WIDTH'(`LINK_REG);
                end
            end
            default: ;
        endcase
    end

    // a conditional branch never carries an absolute target too
    always_comb
    begin
        assert final (!(claim && word.branch && word.absJump))
            else $error("branch and absolute jump in one claimed word");
    end

endmodule

/* logic/immDecoder.sv */
`timescale 1ns/1ps
`include "decoder_config.svh"

module immDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instrFields_t fields,
    output controlWord_t word,
    output logic         claim
);

    logic [15:0]            imm;
    logic [`WORD_WIDTH-1:0] signExt;
    logic [`WORD_WIDTH-1:0] zeroExt;

    assign imm = fields.body.i.imm16;
    assign signExt = {{(`WORD_WIDTH-16){imm[15]}}, imm};
    assign zeroExt = `WORD_WIDTH'(imm);

    always_comb
    begin
        word = kControlNop;
        claim = 1'b1;
        word.regRead1 = fields.body.i.rs; // base or A operand
        word.immediate = signExt;
        case (fields.opcode)
            opAddiu, opAddi, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                word.destinationRegister = fields.body.i.rt;
                word.aluSrc = 1'b1;
                word.grfWriteSource = grfAlu;
                word.aluCtrl = aluAdd;
                case (fields.opcode)
                    opAddi:  word.checkOverflow = 1'b1;
                    opSlti:  word.aluCtrl = aluSlt;
                    opSltiu: word.aluCtrl = aluSltu;
                    opAndi:  word.aluCtrl = aluAnd;
                    opOri:   word.aluCtrl = aluOr;
                    opXori:  word.aluCtrl = aluXor;
                    opLui:   word.immediate = {imm, {(`WORD_WIDTH-16){1'b0}}};
                    default: ;
                endcase
                if (fields.opcode inside {opAndi, opOri, opXori})
                    word.immediate = zeroExt;
            end
            opLw, opLh, opLhu, opLb, opLbu:
            begin
                word.memLoad = 1'b1;
                word.calculateAddress = 1'b1;
                word.grfWriteSource = grfMem;
                word.destinationRegister = fields.body.i.rt;
                word.memReadSignExtend = fields.opcode inside {opLh, opLb};
            end
            opSw, opSh, opSb:
            begin
                word.memStore = 1'b1;
                word.calculateAddress = 1'b1;
                word.regRead2 = fields.body.i.rt; // store data
            end
            default:
            begin
                claim = 1'b0;
                word = kControlNop;
            end
        endcase

        case (fields.opcode)
            opLw, opSw:        word.memWidthCtrl = memWord;
            opLh, opLhu, opSh: word.memWidthCtrl = memHalf;
            default:           word.memWidthCtrl = memByte;
        endcase
    end

endmodule

/* logic/instructionDecoder.sv */
`timescale 1ns/1ps
`include "decoder_config.svh"

module instructionDecoder
    import isaPkg::*;
    import ctrlPkg::*;
#(
    parameter bit implementLikely = `IMPLEMENT_LIKELY_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`WORD_WIDTH-1:0] instruction,
    input  logic                   bubble,
    output controlWord_t           controls
);

    instrFields_t fields;
    controlWord_t specWord;
    controlWord_t branchWord;
    controlWord_t immWord;
    controlWord_t decoded;
    logic         specClaim;
    logic         branchClaim;
    logic         immClaim;

    assign fields = instrFields_t'(instruction);

    specialDecoder specDec (
        .fields (fields),
        .word   (specWord),
        .claim  (specClaim)
    );

    branchDecoder #(
        .implementLikely (implementLikely)
    ) branchDec (
        .fields (fields),
        .word   (branchWord),
        .claim  (branchClaim)
    );

    immDecoder immDec (
        .fields (fields),
        .word   (immWord),
        .claim  (immClaim)
    );

    always_comb
    begin
        decoded = kControlNop;
        if (specClaim)
            decoded = specWord;
        else if (branchClaim)
            decoded = branchWord;
        else if (immClaim)
            decoded = immWord;
        else
            decoded.generateException = excUnknown;
        decoded.mulEnable = decoded.mulCtrl != mulDisabled;
    end

    always_ff @(posedge clk)
    begin
        if (rst || bubble)
            controls <= kControlNop; // bubble squashes whatever was fetched
        else
            controls <= decoded;
    end

    // sub-decoders own disjoint opcode spaces
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({specClaim, branchClaim, immClaim}));

    assert property (@(posedge clk) rst |=> controls == kControlNop);

endmodule

/* test/decoderVectors.svh */
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

typedef struct packed {
    logic [`WORD_WIDTH-1:0] instr;
    logic                   bubble;
    logic [4:0]             rr1;
    logic [4:0]             rr2;
    logic [4:0]             dest;
    logic                   aluSrc;
    logic [`WORD_WIDTH-1:0] imm;
    logic                   ovf;   // checkOverflow
    logic [3:0]             mem;   // load, store, sign extend, calculate address
    logic [2:0]             br;    // branch, likely, absolute jump
    logic                   hiSel; // mulOutputSel
    aluCtrl_t               alu;
    memWidth_t              width;
    cmpCtrl_t               cmp;
    jumpLoc_t               jloc;
    mulCtrl_t               mul;
    grfSrc_t                grf;
    excCode_t               exc;
} vector_t;

localparam int kNumVectors = 45;

localparam vector_t kVectors [kNumVectors] = '{
    '{32'h012a4021, 1'b0, 5'd9, 5'd10, 5'd8, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // addu
    '{32'h012a4020, 1'b0, 5'd9, 5'd10, 5'd8, 1'b0, 32'h00000000, 1'b1, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // add
    '{32'h00851823, 1'b0, 5'd4, 5'd5, 5'd3, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluSub, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // subu
    '{32'h00851822, 1'b0, 5'd4, 5'd5, 5'd3, 1'b0, 32'h00000000, 1'b1, 4'b0000, 3'b000, 1'b0,
      aluSub, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // sub
    '{32'h0043082b, 1'b0, 5'd2, 5'd3, 5'd1, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluSltu, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // sltu
    '{32'h000521c0, 1'b0, 5'd5, 5'd0, 5'd4, 1'b1, 32'h00000007, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluShiftLeft, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // sll 7
    '{32'h000527c3, 1'b0, 5'd5, 5'd0, 5'd4, 1'b1, 32'h0000001f, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluArithShiftRight, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone},
    '{32'h01073006, 1'b0, 5'd7, 5'd8, 5'd6, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluShiftRight, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // srlv
    '{32'h03e00008, 1'b0, 5'd31, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b001, 1'b0,
      aluAdd, memByte, cmpEqual, jumpRegister, mulDisabled, grfAlu, excNone}, // jr
    '{32'h01201009, 1'b0, 5'd9, 5'd0, 5'd2, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b001, 1'b0,
      aluAdd, memByte, cmpEqual, jumpRegister, mulDisabled, grfPc, excNone}, // jalr
    '{32'h00850018, 1'b0, 5'd4, 5'd5, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulMult, grfAlu, excNone},
    '{32'h0085001a, 1'b0, 5'd4, 5'd5, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDiv, grfAlu, excNone},
    '{32'h00c00011, 1'b0, 5'd6, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulSetHi, grfAlu, excNone},
    '{32'h00c00013, 1'b0, 5'd6, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulSetLo, grfAlu, excNone},
    '{32'h00003810, 1'b0, 5'd0, 5'd0, 5'd7, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b1,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfMul, excNone}, // mfhi
    '{32'h00003812, 1'b0, 5'd0, 5'd0, 5'd7, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfMul, excNone}, // mflo
    '{32'h0000000c, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excSyscall},
    '{32'h0000000d, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excBreak},
    '{32'h012a4001, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excUnknown}, // funct 01
    '{32'h24c5fffc, 1'b0, 5'd6, 5'd0, 5'd5, 1'b1, 32'hfffffffc, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // addiu
    '{32'h20c5fffc, 1'b0, 5'd6, 5'd0, 5'd5, 1'b1, 32'hfffffffc, 1'b1, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // addi
    '{32'h28c58000, 1'b0, 5'd6, 5'd0, 5'd5, 1'b1, 32'hffff8000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluSlt, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // slti
    '{32'h30c58001, 1'b0, 5'd6, 5'd0, 5'd5, 1'b1, 32'h00008001, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAnd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // andi
    '{32'h34c5f00f, 1'b0, 5'd6, 5'd0, 5'd5, 1'b1, 32'h0000f00f, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluOr, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // ori
    '{32'h3c051234, 1'b0, 5'd0, 5'd0, 5'd5, 1'b1, 32'h12340000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // lui
    '{32'h8fa2fff8, 1'b0, 5'd29, 5'd0, 5'd2, 1'b0, 32'hfffffff8, 1'b0, 4'b1001, 3'b000, 1'b0,
      aluAdd, memWord, cmpEqual, jumpImmediate, mulDisabled, grfMem, excNone}, // lw
    '{32'h84620006, 1'b0, 5'd3, 5'd0, 5'd2, 1'b0, 32'h00000006, 1'b0, 4'b1011, 3'b000, 1'b0,
      aluAdd, memHalf, cmpEqual, jumpImmediate, mulDisabled, grfMem, excNone}, // lh
    '{32'h90620006, 1'b0, 5'd3, 5'd0, 5'd2, 1'b0, 32'h00000006, 1'b0, 4'b1001, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfMem, excNone}, // lbu
    '{32'ha464fffe, 1'b0, 5'd3, 5'd4, 5'd0, 1'b0, 32'hfffffffe, 1'b0, 4'b0101, 3'b000, 1'b0,
      aluAdd, memHalf, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // sh
    '{32'ha0640001, 1'b0, 5'd3, 5'd4, 5'd0, 1'b0, 32'h00000001, 1'b0, 4'b0101, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // sb
    '{32'h1022ffff, 1'b0, 5'd1, 5'd2, 5'd0, 1'b0, 32'hffffffff, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // beq
    '{32'h14220010, 1'b0, 5'd1, 5'd2, 5'd0, 1'b0, 32'h00000010, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpNotEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // bne
    '{32'h18600008, 1'b0, 5'd3, 5'd0, 5'd0, 1'b0, 32'h00000008, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpAtOrBelowZero, jumpImmediate, mulDisabled, grfAlu, excNone},
    '{32'h1c600008, 1'b0, 5'd3, 5'd0, 5'd0, 1'b0, 32'h00000008, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpAboveZero, jumpImmediate, mulDisabled, grfAlu, excNone}, // bgtz
    '{32'h0460fffe, 1'b0, 5'd3, 5'd0, 5'd0, 1'b0, 32'hfffffffe, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpBelowZero, jumpImmediate, mulDisabled, grfAlu, excNone}, // bltz
    '{32'h04710004, 1'b0, 5'd3, 5'd0, 5'd31, 1'b0, 32'h00000004, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpAtOrAboveZero, jumpImmediate, mulDisabled, grfPc, excNone}, // bgezal
    '{32'h04700004, 1'b0, 5'd3, 5'd0, 5'd31, 1'b0, 32'h00000004, 1'b0, 4'b0000, 3'b100, 1'b0,
      aluAdd, memByte, cmpBelowZero, jumpImmediate, mulDisabled, grfPc, excNone}, // bltzal
    '{32'h50220004, 1'b0, 5'd1, 5'd2, 5'd0, 1'b0, 32'h00000004, 1'b0, 4'b0000, 3'b110, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // beql
    '{32'h04630004, 1'b0, 5'd3, 5'd0, 5'd0, 1'b0, 32'h00000004, 1'b0, 4'b0000, 3'b110, 1'b0,
      aluAdd, memByte, cmpAtOrAboveZero, jumpImmediate, mulDisabled, grfAlu, excNone}, // bgezl
    '{32'h08100040, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00100040, 1'b0, 4'b0000, 3'b001, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // j
    '{32'h0fffffff, 1'b0, 5'd0, 5'd0, 5'd31, 1'b0, 32'h03ffffff, 1'b0, 4'b0000, 3'b001, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfPc, excNone}, // jal
    '{32'h012a4021, 1'b1, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone}, // bubbled addu
    '{32'h0000000c, 1'b1, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excNone},
    '{32'h04650004, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excUnknown}, // regimm 05
    '{32'hfc000000, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h00000000, 1'b0, 4'b0000, 3'b000, 1'b0,
      aluAdd, memByte, cmpEqual, jumpImmediate, mulDisabled, grfAlu, excUnknown}  // opcode 3f
};

`endif

/* test/tbDecoder.sv */
`timescale 1ns/1ps
`include "decoder_config.svh"

module tbDecoder
    import ctrlPkg::*;
();

    `include "decoderVectors.svh"

    localparam int kResetCycles = 8;
    localparam int kRandomCount = 40;
    localparam int kCycleLimit = kResetCycles + kNumVectors + kRandomCount + 20;

    logic                   clk;
    logic                   rst;
    logic [`WORD_WIDTH-1:0] instruction;
    logic                   bubble;
    controlWord_t           controls;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    instructionDecoder u_instructionDecoder (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .bubble      (bubble),
        .controls    (controls)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= kCycleLimit)
        begin
            $display("timeout: decoder run still going after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic checkField(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic compareWord(input controlWord_t expected, input controlWord_t actual);
        checkField("regRead1", expected.regRead1, actual.regRead1);
        checkField("regRead2", expected.regRead2, actual.regRead2);
        checkField("destinationRegister", expected.destinationRegister,
            actual.destinationRegister);
        checkField("aluCtrl", expected.aluCtrl, actual.aluCtrl);
        checkField("aluSrc", expected.aluSrc, actual.aluSrc);
        checkField("immediate", expected.immediate, actual.immediate);
        checkField("checkOverflow", expected.checkOverflow, actual.checkOverflow);
        checkField("branch", expected.branch, actual.branch);
        checkField("branchLikely", expected.branchLikely, actual.branchLikely);
        checkField("cmpCtrl", expected.cmpCtrl, actual.cmpCtrl);
        checkField("absJump", expected.absJump, actual.absJump);
        checkField("absJumpLoc", expected.absJumpLoc, actual.absJumpLoc);
        checkField("memLoad", expected.memLoad, actual.memLoad);
        checkField("memStore", expected.memStore, actual.memStore);
        checkField("memWidthCtrl", expected.memWidthCtrl, actual.memWidthCtrl);
        checkField("memReadSignExtend", expected.memReadSignExtend, actual.memReadSignExtend);
        checkField("calculateAddress", expected.calculateAddress, actual.calculateAddress);
        checkField("mulCtrl", expected.mulCtrl, actual.mulCtrl);
        checkField("mulEnable", expected.mulEnable, actual.mulEnable);
        checkField("mulOutputSel", expected.mulOutputSel, actual.mulOutputSel);
        checkField("grfWriteSource", expected.grfWriteSource, actual.grfWriteSource);
        checkField("generateException", expected.generateException, actual.generateException);
    endtask

    function automatic controlWord_t expectFromRow(input vector_t v);
        controlWord_t w;
        w = kControlNop;
        w.regRead1 = v.rr1;
        w.regRead2 = v.rr2;
        w.destinationRegister = v.dest;
        w.aluCtrl = v.alu;
        w.aluSrc = v.aluSrc;
        w.immediate = v.imm;
        w.checkOverflow = v.ovf;
        {w.memLoad, w.memStore, w.memReadSignExtend, w.calculateAddress} = v.mem;
        w.memWidthCtrl = v.width;
        {w.branch, w.branchLikely, w.absJump} = v.br;
        w.cmpCtrl = v.cmp;
        w.absJumpLoc = v.jloc;
        w.mulCtrl = v.mul;
        w.mulEnable = v.mul != mulDisabled; // multiplier busy for any real operation
        w.mulOutputSel = v.hiSel;
        w.grfWriteSource = v.grf;
        w.generateException = v.exc;
        return w;
    endfunction

    // major opcodes of the kept instruction set
    function automatic bit isImplementedOpcode(input logic [5:0] op);
        return op inside {[6'h00:6'h0f], [6'h14:6'h17], 6'h20, 6'h21, 6'h23, 6'h24,
            6'h25, 6'h28, 6'h29, 6'h2b};
    endfunction

    task automatic applyWord(input logic [31:0] instr, input logic bub,
        input controlWord_t expected);
        instruction = instr;
        bubble = bub;
        @(posedge clk);
        #1; // stage register loaded at this edge
        compareWord(expected, controls);
    endtask

    initial
    begin
        logic [31:0]  randWord;
        controlWord_t unknownWord;

        void'($urandom(32'hcd6f3086));
        rst = 1'b1;
        bubble = 1'b0;
        instruction = kVectors[0].instr; // a valid word, still squashed by reset
        repeat (kResetCycles)
        begin
            @(posedge clk);
            #1;
            compareWord(kControlNop, controls);
        end
        rst = 1'b0;

        for (int i = 0; i < kNumVectors; i++)
            applyWord(kVectors[i].instr, kVectors[i].bubble, expectFromRow(kVectors[i]));

        unknownWord = kControlNop;
        unknownWord.generateException = excUnknown;
        for (int i = 0; i < kRandomCount; i++)
        begin
            randWord = $urandom;
            while (isImplementedOpcode(randWord[31:26]))
                randWord[31:26] = 6'($urandom);
            applyWord(randWord, 1'b0, unknownWord);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
+incdir+test
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/specialDecoder.sv
logic/branchDecoder.sv
logic/immDecoder.sv
logic/instructionDecoder.sv
test/tbDecoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbDecoder
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
